// File: Makefile
# verilator flow for the uart transmit subsystem
#   make        build and run, pass is found in the log
#   make lint   lint the sources
#   make clean  remove build output

VERILATOR ?= verilator
TOP       ?= uart_tx_tb
SEED      ?= 49537
LOG       ?= run.log
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

PASS_MSG  = Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "run failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: common/uart_defines.svh
/* uart tx subsystem macros
   fifo geometry, apb address width and register byte offsets */

`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

////////////////////////////////////////
// transmit fifo geometry
`define UART_FIFO_DEPTH 16
`define UART_FIFO_PTR_W 4
`define UART_FIFO_CNT_W 5 // one more than ptr, holds 0..16

////////////////////////////////////////
// apb register map
`define UART_APB_ADDR_W 5

`define UART_REG_THR 5'h00 // write only, pushes a char
`define UART_REG_LCR 5'h04
`define UART_REG_DIV 5'h08
`define UART_REG_FCR 5'h0C // write only, bit 0 flushes
`define UART_REG_LSR 5'h10 // read only

`endif

// File: common/uart_line_pkg.sv
/* serial line types for the uart transmitter
   character, divisor and counter widths plus the frame fsm states */

`default_nettype none

`include "uart_defines.svh"

package uart_line_pkg;

  typedef logic [7:0]  uart_char_t;  // up to 8 data bits
  typedef logic [15:0] divisor_t;    // clk cycles per 16x tick

  // fifo fill level
  typedef logic [`UART_FIFO_CNT_W-1:0] fifo_count_t;

  typedef logic [4:0] bit_tick_t;    // ticks within one bit, up to 32 for 2 stop bits

  ////////////////////////////////////////
  // transmitter fsm
  typedef enum logic [2:0] {
    TX_IDLE   = 3'd0,
    TX_POP    = 3'd1, // wait for tick to take head char
    TX_START  = 3'd2,
    TX_DATA   = 3'd3,
    TX_PARITY = 3'd4,
    TX_STOP   = 3'd5
  } tx_state_e;

endpackage

`default_nettype wire

// File: common/uart_reg_pkg.sv
/* register map types for the uart transmitter
   apb request, lcr and lsr layouts and register offsets */

`default_nettype none

`include "uart_defines.svh"

package uart_reg_pkg;
  import uart_line_pkg::*;

  // master side of the apb bus
  typedef struct packed {
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    logic [`UART_APB_ADDR_W-1:0] paddr;
    logic [31:0]                 pwdata;
  } apb_req_t;

  ////////////////////////////////////////
  // line control, 16550 layout minus dlab
  typedef struct packed {
    logic       rsvd;
    logic       brk;  // hold line low
    logic       sp;   // stick parity
    logic       ep;   // even parity
    logic       pe;   // parity enable
    logic       sb;   // 0 = 1 stop, 1 = 1.5 or 2
    logic [1:0] wls;  // 5..8 bits
  } lcr_t;

  // line status, 8 bits wide
  typedef struct packed {
    fifo_count_t count;
    logic        overrun; // sticky, cleared on read
    logic        temt;    // fifo empty and shifter idle
    logic        thre;    // fifo empty
  } lsr_t;

  typedef enum logic [`UART_APB_ADDR_W-1:0] {
    REG_THR = `UART_REG_THR,
    REG_LCR = `UART_REG_LCR,
    REG_DIV = `UART_REG_DIV,
    REG_FCR = `UART_REG_FCR,
    REG_LSR = `UART_REG_LSR
  } reg_addr_e;

endpackage

`default_nettype wire

// File: design/uart_apb_regs.sv
/* apb slave for the uart transmitter
   holds lcr, divisor and sticky overrun, decodes thr and fcr writes into fifo strobes */

`timescale 1ns/1ps
`default_nettype none

module uart_apb_regs import uart_reg_pkg::*, uart_line_pkg::*; (
  input  wire         clk,
  input  wire         wb_rst_i,
  input  apb_req_t    apb_req_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output lcr_t        lcr_o,
  output divisor_t    divisor_o,
  output logic        push_o,
  output uart_char_t  push_data_o,
  output logic        flush_o,
  input  fifo_count_t count_i,
  input  wire         overrun_i,
  input  wire         busy_i
);

  lcr_t      lcr_q;
  divisor_t  div_q;
  logic      ovr_q;     // sticky overrun
  logic      wr_acc;
  logic      rd_acc;
  reg_addr_e addr;
  lsr_t      lsr;

  ////////////////////////////////////////
  // access decode
  assign addr   = reg_addr_e'(apb_req_i.paddr);
  assign wr_acc = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;
  assign rd_acc = apb_req_i.psel & apb_req_i.penable & ~apb_req_i.pwrite;

  assign pready_o = 1'b1; // no wait states

  // fifo strobes, live only in the access cycle
  assign push_o      = wr_acc && (addr == REG_THR);
  assign push_data_o = apb_req_i.pwdata[7:0];
  assign flush_o     = wr_acc && (addr == REG_FCR) && apb_req_i.pwdata[0];

  ////////////////////////////////////////
  // control registers
  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      lcr_q <= '0;
      div_q <= '0; // baud stopped until sw writes it
    end else if (wr_acc) begin
      case (addr)
        REG_LCR: lcr_q <= lcr_t'(apb_req_i.pwdata[7:0]);
        REG_DIV: div_q <= apb_req_i.pwdata[15:0];
        default: ;
      endcase
    end
  end

  // set has priority over the read clear
  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i)
      ovr_q <= 1'b0;
    else if (overrun_i)
      ovr_q <= 1'b1;
    else if (rd_acc && (addr == REG_LSR))
      ovr_q <= 1'b0;
  end

  assign lcr_o     = lcr_q;
  assign divisor_o = div_q;

  ////////////////////////////////////////
  // status and readback
  assign lsr.count   = count_i;
  assign lsr.overrun = ovr_q;
  assign lsr.thre    = (count_i == '0);
  assign lsr.temt    = (count_i == '0) & ~busy_i;

  always_comb begin
    case (addr)
      REG_LCR: prdata_o = {24'd0, lcr_q};
      REG_DIV: prdata_o = {16'd0, div_q};
      REG_LSR: prdata_o = {24'd0, lsr};
      default: prdata_o = 32'd0; // thr, fcr and holes read zero
    endcase
  end

  // flush strobe empties the fifo by the next cycle
  a_flush_empties: assert property (@(posedge clk) disable iff (wb_rst_i)
    flush_o |=> (count_i == '0));

endmodule

`default_nettype wire

// File: design/uart_baud_gen.sv
/* baud rate generator
   divides clk by the divisor into a one-cycle 16x oversampling tick */

`timescale 1ns/1ps
`default_nettype none

module uart_baud_gen import uart_line_pkg::*; (
  input  wire      clk,
  input  wire      wb_rst_i,
  input  divisor_t divisor_i,
  output logic     tick_o
);

  divisor_t cnt_q;
  divisor_t div_seen_q; // last divisor, for change detect
  logic     div_chg;
  logic     last_cnt;

  assign div_chg  = (divisor_i != div_seen_q);
  assign last_cnt = (cnt_q == divisor_i - 16'd1);

  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      cnt_q      <= '0;
      div_seen_q <= '0;
    end else begin
      div_seen_q <= divisor_i;
      if (div_chg || (divisor_i == '0) || last_cnt)
        cnt_q <= '0; // restart on new divisor or wrap
      else
        cnt_q <= cnt_q + 16'd1;
    end
  end

  // gated while stopped and in the restart cycle
  assign tick_o = (divisor_i != '0) && !div_chg && last_cnt;

  a_tick_spacing: assert property (@(posedge clk) disable iff (wb_rst_i)
    tick_o |=> (!tick_o || (divisor_i == 16'd1)));

endmodule

`default_nettype wire

// File: design/uart_tx_top.sv
/* uart transmit subsystem top
   apb registers, baud generator, tx fifo and frame transmitter */

`timescale 1ns/1ps
`default_nettype none

module uart_tx_top import uart_reg_pkg::*, uart_line_pkg::*; (
  input  wire         clk,
  input  wire         wb_rst_i,
  input  apb_req_t    apb_req_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        stx_pad_o
);

  lcr_t        lcr;
  divisor_t    divisor;
  logic        push;
  uart_char_t  push_data;
  logic        flush;
  logic        pop;
  uart_char_t  head_data;
  fifo_count_t count;
  logic        overrun;
  logic        busy;
  logic        tick;

  ////////////////////////////////////////
  // cpu side
  uart_apb_regs uart_apb_regs_inst (
    .clk         (clk),
    .wb_rst_i    (wb_rst_i),
    .apb_req_i   (apb_req_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .lcr_o       (lcr),
    .divisor_o   (divisor),
    .push_o      (push),
    .push_data_o (push_data),
    .flush_o     (flush),
    .count_i     (count),
    .overrun_i   (overrun),
    .busy_i      (busy)
  );

  uart_baud_gen uart_baud_gen_inst (
    .clk       (clk),
    .wb_rst_i  (wb_rst_i),
    .divisor_i (divisor),
    .tick_o    (tick)
  );

  ////////////////////////////////////////
  // line side
  uart_tx_fifo uart_tx_fifo_inst (
    .clk       (clk),
    .wb_rst_i  (wb_rst_i),
    .push_i    (push),
    .data_i    (push_data),
    .pop_i     (pop),
    .flush_i   (flush),
    .data_o    (head_data),
    .count_o   (count),
    .overrun_o (overrun)
  );

  uart_transmitter uart_transmitter_inst (
    .clk      (clk),
    .wb_rst_i (wb_rst_i),
    .tick_i   (tick),
    .lcr_i    (lcr),
    .data_i   (head_data),
    .count_i  (count),
    .pop_o    (pop),
    .busy_o   (busy),
    .stx_o    (stx_pad_o)
  );

endmodule

`default_nettype wire

// File: sources.f
+incdir+common
common/uart_line_pkg.sv
common/uart_reg_pkg.sv
design/uart_apb_regs.sv
design/uart_baud_gen.sv
uart_tx/uart_tx_fifo.sv
uart_tx/uart_transmitter.sv
design/uart_tx_top.sv
verif/uart_tx_tb.sv

// File: uart_tx/uart_transmitter.sv
/* uart frame transmitter
   start, 5..8 data bits lsb first, optional parity and 1/1.5/2 stop bits on ticks */

`timescale 1ns/1ps
`default_nettype none

module uart_transmitter import uart_reg_pkg::*, uart_line_pkg::*; (
  input  wire         clk,
  input  wire         wb_rst_i,
  input  wire         tick_i,
  input  lcr_t        lcr_i,
  input  uart_char_t  data_i,
  input  fifo_count_t count_i,
  output logic        pop_o,
  output logic        busy_o,
  output logic        stx_o
);

  tx_state_e  state_q;
  bit_tick_t  tick_cnt_q; // position inside current bit
  bit_tick_t  bit_last;
  bit_tick_t  stop_last;
  logic       bit_done;
  logic [2:0] bit_cnt_q;  // data bits still to go
  logic [6:0] shift_q;
  logic       bit_q;      // bit on the line in data and parity
  logic       par_q;      // xor of the latched data bits
  logic [1:0] wls_q;
  logic       par_calc;
  logic       par_bit;
  logic       take;
  logic       line_d;
  logic       line_q;

  ////////////////////////////////////////
  // bit timing
  always_comb begin
    if (!lcr_i.sb)
      stop_last = 5'd15;   // 1 stop bit
    else if (wls_q == 2'd0)
      stop_last = 5'd23;   // 1.5 stop with 5 bit words
    else
      stop_last = 5'd31;   // 2 stop bits
  end

  assign bit_last = (state_q == TX_STOP) ? stop_last : 5'd15;
  assign bit_done = (tick_cnt_q == bit_last);

  // parity over the word length in use
  always_comb begin
    case (lcr_i.wls)
      2'd0:    par_calc = ^data_i[4:0];
      2'd1:    par_calc = ^data_i[5:0];
      2'd2:    par_calc = ^data_i[6:0];
      default: par_calc = ^data_i[7:0];
    endcase
  end

  always_comb begin
    case ({lcr_i.ep, lcr_i.sp})
      2'b00:   par_bit = ~par_q; // odd
      2'b01:   par_bit = 1'b1;   // stick 1
      2'b10:   par_bit = par_q;  // even
      default: par_bit = 1'b0;   // stick 0
    endcase
  end

  assign take   = tick_i && (state_q == TX_POP) && (count_i != '0);
  assign pop_o  = take;
  assign busy_o = (state_q != TX_IDLE);

  ////////////////////////////////////////
  // frame fsm
  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      state_q    <= TX_IDLE;
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
    end else if (tick_i) begin
      if (state_q == TX_IDLE || state_q == TX_POP || bit_done)
        tick_cnt_q <= '0;
      else
        tick_cnt_q <= tick_cnt_q + 5'd1;

      case (state_q)
        TX_IDLE: begin
          if (count_i != '0)
            state_q <= TX_POP;
        end
        TX_POP: begin
          if (take) begin
            bit_cnt_q <= 3'd4 + {1'b0, lcr_i.wls}; // 4..7 shifts left after first bit
            state_q   <= TX_START;
          end else begin
            state_q <= TX_IDLE; // flushed meanwhile
          end
        end
        TX_START: begin
          if (bit_done)
            state_q <= TX_DATA;
        end
        TX_DATA: begin
          if (bit_done) begin
            if (bit_cnt_q != 3'd0)
              bit_cnt_q <= bit_cnt_q - 3'd1;
            else if (lcr_i.pe)
              state_q <= TX_PARITY;
            else
              state_q <= TX_STOP;
          end
        end
        TX_PARITY: begin
          if (bit_done)
            state_q <= TX_STOP;
        end
        TX_STOP: begin
          if (bit_done)
            state_q <= TX_IDLE;
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  // payload path, latched at pop and shifted per data bit
  always_ff @(posedge clk) begin
    if (take) begin
      {shift_q, bit_q} <= data_i;
      par_q            <= par_calc;
      wls_q            <= lcr_i.wls;
    end else if (tick_i && bit_done && state_q == TX_DATA) begin
      if (bit_cnt_q != 3'd0)
        {shift_q, bit_q} <= {1'b0, shift_q};
      else
        bit_q <= par_bit; // only seen if parity enabled
    end
  end

  ////////////////////////////////////////
  // line output
  always_comb begin
    case (state_q)
      TX_START:           line_d = 1'b0;
      TX_DATA, TX_PARITY: line_d = bit_q;
      default:            line_d = 1'b1; // idle, pop, stop
    endcase
  end

  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i)
      line_q <= 1'b1;
    else
      line_q <= line_d; // registered pad drive
  end

  assign stx_o = lcr_i.brk ? 1'b0 : line_q; // break overrides frame

  a_pop_pulse: assert property (@(posedge clk) disable iff (wb_rst_i)
    pop_o |=> !pop_o);

  a_idle_mark: assert property (@(posedge clk) disable iff (wb_rst_i)
    (state_q == TX_IDLE && !lcr_i.brk) |-> stx_o);

endmodule

`default_nettype wire

// File: uart_tx/uart_tx_fifo.sv
/* transmit fifo, 16 entries
   circular buffer with fill count, overrun pulse on full push and flush */

`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module uart_tx_fifo import uart_line_pkg::*; (
  input  wire         clk,
  input  wire         wb_rst_i,
  input  wire         push_i,
  input  uart_char_t  data_i,
  input  wire         pop_i,
  input  wire         flush_i,
  output uart_char_t  data_o,
  output fifo_count_t count_o,
  output logic        overrun_o
);

  uart_char_t                  mem [`UART_FIFO_DEPTH];
  logic [`UART_FIFO_PTR_W-1:0] wr_ptr_q;
  logic [`UART_FIFO_PTR_W-1:0] rd_ptr_q;
  fifo_count_t                 cnt_q;
  logic                        full;
  logic                        empty;
  logic                        do_push;
  logic                        do_pop;

  assign full    = (cnt_q == fifo_count_t'(`UART_FIFO_DEPTH));
  assign empty   = (cnt_q == '0);
  assign do_push = push_i & ~full;
  assign do_pop  = pop_i & ~empty;

  assign overrun_o = push_i & full; // char dropped
  assign data_o    = mem[rd_ptr_q]; // head, read combinationally
  assign count_o   = cnt_q;

  ////////////////////////////////////////
  // pointers and count
  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push)
        wr_ptr_q <= wr_ptr_q + 1'b1; // wraps at depth
      if (do_pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: ; // both or none, level unchanged
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (do_push)
      mem[wr_ptr_q] <= data_i;
  end

  a_cnt_bound: assert property (@(posedge clk) disable iff (wb_rst_i)
    cnt_q <= fifo_count_t'(`UART_FIFO_DEPTH));

  // transmitter checks the level before it pops
  a_no_empty_pop: assert property (@(posedge clk) disable iff (wb_rst_i)
    pop_i |-> (cnt_q != '0));

endmodule

`default_nettype wire

// File: verif/uart_tx_tb.sv
/* testbench for the uart transmit subsystem
   apb driver, serial line model and random frame checks */

`timescale 1ns/1ps
`default_nettype none

`include "uart_defines.svh"

module uart_tx_tb
  import uart_reg_pkg::*, uart_line_pkg::*;
#(
  parameter logic [31:0] SEED = 32'd49537
) ();

  localparam int N_CFG       = 8;  // lcr settings tried
  localparam int BURST_LEN   = 5;
  localparam int DRAIN_LEN   = 16; // one full fifo
  localparam int BAUD_DIV    = 2;
  localparam int TOTAL_CHARS = N_CFG * BURST_LEN + DRAIN_LEN;
  // 33 bit times per char, far above the longest frame
  localparam int TIMEOUT_CYCLES = TOTAL_CHARS * 33 * 16 * BAUD_DIV + 20000;
  localparam int K_REG  = 0;
  localparam int K_LINE = 1;
  localparam int K_STAT = 2;

  logic        clk = 1'b0;
  logic        wb_rst_i;
  apb_req_t    apb_req_i;
  logic [31:0] prdata_o;
  logic        pready_o;
  logic        stx_pad_o;

  logic [31:0] rng_q = SEED;
  int          err_cnt [3] = '{0, 0, 0}; // register, line, status
  int          cycle_cnt = 0;
  int          frames_rx = 0;
  bit          watch_en = 1'b0;
  lcr_t        lcr_sh = '0;              // last value written to lcr
  int          div_sh = 0;
  uart_char_t  exp_q [$];                // chars owed to the line

  uart_tx_top uart_tx_top_inst (
    .clk       (clk),
    .wb_rst_i  (wb_rst_i),
    .apb_req_i (apb_req_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .stx_pad_o (stx_pad_o)
  );

  always #50 clk = ~clk; // 100 ns period

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
      finish_run(1'b1);
    end
  end

  ////////////////////////////////////////
  // reference rules
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function logic [31:0] next_rand();
    rng_q = xorshift32(rng_q);
    return rng_q;
  endfunction

  function automatic uart_char_t word_mask(input lcr_t l);
    return 8'hFF >> (3 - l.wls); // 5..8 low bits
  endfunction

  function automatic logic parity_bit(input uart_char_t d, input lcr_t l);
    logic x;
    x = ^(d & word_mask(l));
    case ({l.ep, l.sp})
      2'b00:   return ~x; // odd
      2'b01:   return 1'b1;
      2'b10:   return x;  // even
      default: return 1'b0;
    endcase
  endfunction

  function automatic int stop_ticks(input lcr_t l);
    if (!l.sb)
      return 16;
    else if (l.wls == 2'd0)
      return 24; // 1.5 stop
    else
      return 32;
  endfunction

  ////////////////////////////////////////
  // checks and apb access
  task automatic check_eq(input string name, input logic [31:0] got,
                          input logic [31:0] exp, input int kind);
    assert (got === exp) else begin
      $display("error t=%0d ns %s: got 0x%0h expected 0x%0h", $time, name, got, exp);
      err_cnt[kind]++;
    end
  endtask

  task automatic check_true(input bit cond, input string what, input int kind);
    assert (cond) else begin
      $display("error t=%0d ns: %s", $time, what);
      err_cnt[kind]++;
    end
  endtask

  task automatic apb_xfer(input bit wr, input logic [`UART_APB_ADDR_W-1:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata);
    apb_req_t req;
    req.psel    = 1'b1;
    req.penable = 1'b0;
    req.pwrite  = wr;
    req.paddr   = addr;
    req.pwdata  = wr ? wdata : 32'd0;
    @(posedge clk);
    apb_req_i <= req;    // setup
    @(posedge clk);
    req.penable = 1'b1;
    apb_req_i <= req;    // access
    @(negedge clk);
    rdata = prdata_o;    // mid access cycle
    check_eq("pready_o", {31'd0, pready_o}, 32'd1, K_REG);
    @(posedge clk);
    apb_req_i <= '0;
  endtask

  task automatic reg_write(input logic [`UART_APB_ADDR_W-1:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    apb_xfer(1'b1, addr, data, unused);
  endtask

  task automatic read_expect(input logic [`UART_APB_ADDR_W-1:0] addr, input logic [31:0] exp,
                             input string name, input int kind);
    logic [31:0] got;
    apb_xfer(1'b0, addr, 32'd0, got);
    check_eq(name, got, exp, kind);
  endtask

  task automatic set_lcr(input logic [7:0] val);
    reg_write(`UART_REG_LCR, {24'd0, val});
    lcr_sh = val;
  endtask

  task automatic set_div(input divisor_t d);
    reg_write(`UART_REG_DIV, {16'd0, d});
    div_sh = int'(d);
  endtask

  task automatic push_char(input uart_char_t c, input bit tracked);
    if (tracked)
      exp_q.push_back(c & word_mask(lcr_sh));
    reg_write(`UART_REG_THR, {24'd0, c});
  endtask

  // poll lsr until the shifter is done
  task automatic wait_drained();
    logic [31:0] lsr;
    lsr = '0;
    while (!lsr[1]) begin
      apb_xfer(1'b0, `UART_REG_LSR, 32'd0, lsr);
      if (lsr[1])
        check_true(exp_q.size() == 0,
                   "lsr temt was set while characters were still on their way", K_STAT);
    end
    check_eq("lsr drained", lsr, 32'h03, K_STAT);
  endtask

  task automatic expect_line(input logic level, input int cycles, input string name);
    logic seen;
    seen = level;
    repeat (cycles) begin
      @(negedge clk);
      if (stx_pad_o !== level)
        seen = stx_pad_o; // keep the odd one
    end
    check_eq(name, {31'd0, seen}, {31'd0, level}, K_LINE);
  endtask

  task automatic finish_run(input bit timed_out);
    int total;
    total = err_cnt[K_REG] + err_cnt[K_LINE] + err_cnt[K_STAT];
    $display("errors: register %0d, line %0d, status %0d, total %0d",
             err_cnt[K_REG], err_cnt[K_LINE], err_cnt[K_STAT], total);
    if (!timed_out && total == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  endtask

  ////////////////////////////////////////
  // serial line receiver model
  initial begin : serial_model
    lcr_t       cfg;
    int         div;
    int         nbits;
    uart_char_t rx;
    uart_char_t exp;
    logic       par;
    logic       stop_seen;
    forever begin
      @(negedge stx_pad_o);
      if (watch_en) begin
        cfg   = lcr_sh;
        div   = div_sh;
        nbits = 5 + int'(cfg.wls);
        rx    = '0;
        par   = 1'b0;
        repeat (8 * div) @(negedge clk); // middle of start bit
        check_eq("stx_pad_o start", {31'd0, stx_pad_o}, 32'd0, K_LINE);
        for (int i = 0; i < nbits; i++) begin
          repeat (16 * div) @(negedge clk);
          rx[i] = stx_pad_o; // lsb first
        end
        if (cfg.pe) begin
          repeat (16 * div) @(negedge clk);
          par = stx_pad_o;
        end
        frames_rx++;
        if (exp_q.size() == 0) begin
          check_true(1'b0, "a frame appeared on the line with no character queued", K_LINE);
        end else begin
          exp = exp_q.pop_front();
          check_eq("stx_pad_o data", {24'd0, rx}, {24'd0, exp}, K_LINE);
          if (cfg.pe)
            check_eq("stx_pad_o parity", {31'd0, par}, {31'd0, parity_bit(exp, cfg)}, K_LINE);
        end
        // whole stop time, first cycle to last
        repeat (8 * div + 1) @(negedge clk);
        stop_seen = stx_pad_o;
        repeat (stop_ticks(cfg) * div - 1) begin
          @(negedge clk);
          if (stx_pad_o !== 1'b1)
            stop_seen = stx_pad_o;
        end
        check_eq("stx_pad_o stop", {31'd0, stop_seen}, 32'd1, K_LINE);
      end
    end
  end

  ////////////////////////////////////////
  // test sequence
  initial begin : main_seq
    logic [7:0]  val;
    logic [31:0] rnd;
    int          prev_frames;
    wb_rst_i  = 1'b1;
    apb_req_i = '0;
    repeat (2) @(posedge clk);
    wb_rst_i <= 1'b0;
    watch_en = 1'b1;

    // reset status, then register readback
    read_expect(`UART_REG_LSR, 32'h03, "lsr after reset", K_STAT);
    for (int i = 0; i < 4; i++) begin
      rnd = next_rand();
      val = rnd[7:0] & 8'hBF; // brk off
      set_lcr(val);
      rnd = next_rand();
      set_div(rnd[15:0]);
      read_expect(`UART_REG_LCR, {24'd0, val}, "lcr", K_REG);
      read_expect(`UART_REG_DIV, {16'd0, rnd[15:0]}, "divisor", K_REG);
    end
    read_expect(`UART_REG_THR, 32'd0, "thr readback", K_REG);

    // frames, word length stepped, parity and stop random
    set_div(16'(BAUD_DIV));
    for (int c = 0; c < N_CFG; c++) begin
      rnd = next_rand();
      set_lcr((rnd[7:0] & 8'h3C) | 8'(c % 4));
      for (int k = 0; k < BURST_LEN; k++) begin
        rnd = next_rand();
        push_char(rnd[7:0], 1'b1);
      end
      wait_drained();
    end

    // full fifo burst, line rests high after
    set_lcr(8'h03);
    for (int k = 0; k < DRAIN_LEN; k++) begin
      rnd = next_rand();
      push_char(rnd[7:0], 1'b1);
    end
    wait_drained();
    prev_frames = frames_rx;
    expect_line(1'b1, 64 * BAUD_DIV, "stx_pad_o after drain");

    // overrun, baud stopped so nothing leaves
    set_div(16'd0);
    for (int k = 0; k < `UART_FIFO_DEPTH + 2; k++) begin
      rnd = next_rand();
      push_char(rnd[7:0], 1'b0);
    end
    read_expect(`UART_REG_LSR, 32'h84, "lsr full with overrun", K_STAT);
    read_expect(`UART_REG_LSR, 32'h80, "lsr after overrun read", K_STAT);

    // flush drops the 16 held chars
    reg_write(`UART_REG_FCR, 32'h1);
    read_expect(`UART_REG_LSR, 32'h03, "lsr after flush", K_STAT);
    set_div(16'(BAUD_DIV));
    expect_line(1'b1, 4 * 16 * BAUD_DIV, "stx_pad_o after flush");
    check_eq("frames after flush", frames_rx, prev_frames, K_LINE);

    // break holds the line low
    watch_en = 1'b0;
    set_lcr(8'h43);
    expect_line(1'b0, 32, "stx_pad_o in break");
    set_lcr(8'h03);
    expect_line(1'b1, 32, "stx_pad_o after break");

    finish_run(1'b0);
  end

endmodule

`default_nettype wire
